/* Makefile */
compile:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_sdram_ctrl -Mdir obj_dir

run: compile
	./obj_dir/Vtb_sdram_ctrl | tee sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: compile run clean

/* src.f */
verilog/sdram_pkg.sv
verilog/sdram_ctlif.sv
verilog/sdram_timer.sv
verilog/sdram_mgmt.sv
verilog/sdram_busif.sv
verilog/sdram_ctrl.sv
verification/sdram_model.sv
verification/tb_sdram_ctrl.sv

/* verification/sdram_model.sv */
// Behavioral x16 SDR SDRAM with 4 banks of 16 rows of 256 words, burst length 1 only.
// Row bits above 3 are ignored. Timing limits are parameters in clock cycles.
`timescale 1ns/10ps
`default_nettype none

module sdram_model #(
	parameter int trcd = 3,
	parameter int trp = 3,
	parameter int trfc = 6,
	parameter int twr = 1
) (
	input wire clk,
	input wire cke,
	input wire cs_n,
	input wire ras_n,
	input wire cas_n,
	input wire we_n,
	input wire [12:0] adr,
	input wire [1:0] ba,
	input wire [1:0] dqm,
	inout wire [15:0] dq,
	output logic violation,
	output int cas_latency,
	output int refresh_count
);

	logic [15:0] mem [0:16383]; // index is {bank, row[3:0], column}.
	logic [3:0] open_row [0:3];
	logic bank_open [0:3];
	int act_time [0:3]; // cycle of the last activate per bank.
	int ready_time [0:3]; // first cycle a bank may be activated again.
	int cycle;
	int refresh_end; // no command before this cycle.
	logic [3:0] rd_pipe = '0; // bit k marks a read issued k+1 edges ago.
	logic [15:0] rd_word [0:3];
	sdram_pkg::sdram_cmd_t cmd;

	assign cmd = sdram_pkg::sdram_cmd_t'({cs_n, ras_n, cas_n, we_n});
	// data is on the pins in the cycle before edge read+CL, so it is stable at that edge.
	assign dq = rd_pipe[cas_latency-1] ? rd_word[cas_latency-1] : 'z;

	task automatic flag(input string what);
		violation = 1'b1;
		$display("model: %s at cycle %0d", what, cycle);
	endtask

	function automatic logic any_open();
		return bank_open[0] | bank_open[1] | bank_open[2] | bank_open[3];
	endfunction

	initial begin
		violation = 1'b0;
		cas_latency = 2; // a sane value until the first MRS.
		refresh_count = 0;
		cycle = 0;
		refresh_end = 0;
		for (int i = 0; i < 16384; i++)
			mem[i] = 16'(i * 40503); // odd multiplier, so every address bit shows.
		for (int b = 0; b < 4; b++) begin
			bank_open[b] = 1'b0;
			open_row[b] = 4'd0;
			act_time[b] = 0;
			ready_time[b] = 0;
		end
	end

	always @(posedge clk) begin
		logic [13:0] idx;
		cycle = cycle + 1;
		idx = {ba, open_row[ba], adr[7:0]};
		rd_pipe <= {rd_pipe[2:0], 1'b0};
		rd_word[1] <= rd_word[0];
		rd_word[2] <= rd_word[1];
		rd_word[3] <= rd_word[2];
		if (cke && !cs_n && cmd != sdram_pkg::CMD_NOP) begin
			if (cycle < refresh_end)
				flag("command inside tRFC");
			case (cmd)
			sdram_pkg::CMD_ACTIVE: begin
				if (bank_open[ba] || cycle < ready_time[ba])
					flag("activate on an open bank or inside tRP");
				bank_open[ba] = 1'b1;
				open_row[ba] = adr[3:0];
				act_time[ba] = cycle;
			end
			sdram_pkg::CMD_READ, sdram_pkg::CMD_WRITE: begin
				if (!bank_open[ba])
					flag("read or write to a closed bank");
				else if (cycle < act_time[ba] + trcd)
					flag("tRCD broken");
				if (cmd == sdram_pkg::CMD_READ) begin
					rd_pipe <= {rd_pipe[2:0], 1'b1};
					rd_word[0] <= mem[idx];
				end else begin
					if (!dqm[0])
						mem[idx][7:0] = dq[7:0]; // dqm high masks the byte.
					if (!dqm[1])
						mem[idx][15:8] = dq[15:8];
				end
				if (adr[10]) begin
					bank_open[ba] = 1'b0; // auto-precharge starts after the burst or tWR.
					ready_time[ba] = cycle + trp + ((cmd == sdram_pkg::CMD_WRITE) ? twr + 1 : 1);
				end
			end
			sdram_pkg::CMD_PRECHARGE: begin
				for (int b = 0; b < 4; b++) begin
					if (adr[10] || b == int'(ba)) begin
						if (bank_open[b])
							ready_time[b] = cycle + trp;
						bank_open[b] = 1'b0;
					end
				end
			end
			sdram_pkg::CMD_REFRESH: begin
				if (any_open())
					flag("refresh with a bank open");
				refresh_end = cycle + trfc;
				refresh_count = refresh_count + 1;
			end
			sdram_pkg::CMD_MRS: begin
				if (any_open())
					flag("mode register set with a bank open");
				cas_latency = int'(adr[6:4]);
			end
			default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

/* verification/tb_sdram_ctrl.sv */
// Testbench for sdram_ctrl with the behavioral SDRAM model.
// Model timing parameters must match the timing word written over the CSR port.
`timescale 1ns/10ps
`default_nettype none

module tb_sdram_ctrl;

	logic sys_clk, rst_n, csr_we, req, we, ack;
	logic [3:0] csr_a;
	logic [31:0] csr_di, csr_do;
	logic [21:0] adr;
	logic [15:0] wdata, rdata;
	logic [1:0] sel, sdram_ba, sdram_dqm;
	logic sdram_cke, sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n;
	logic [12:0] sdram_adr;
	wire [15:0] sdram_dq;
	logic model_violation, ack_q, req_q;
	int model_cl, model_refs, errors, checks, hs_errors;

	string t_name[$]; // stimulus table, one entry per bus access.
	logic t_we[$];
	logic [21:0] t_adr[$];
	logic [15:0] t_wdata[$], t_exp[$];
	logic [1:0] t_sel[$];

	sdram_ctrl sdram_ctrl_inst (.sys_clk(sys_clk), .rst_n(rst_n), .csr_a(csr_a),
		.csr_we(csr_we), .csr_di(csr_di), .csr_do(csr_do), .req(req), .we(we), .adr(adr),
		.wdata(wdata), .sel(sel), .ack(ack), .rdata(rdata), .sdram_cke(sdram_cke),
		.sdram_cs_n(sdram_cs_n), .sdram_ras_n(sdram_ras_n), .sdram_cas_n(sdram_cas_n),
		.sdram_we_n(sdram_we_n), .sdram_adr(sdram_adr), .sdram_ba(sdram_ba),
		.sdram_dqm(sdram_dqm), .sdram_dq(sdram_dq));

	sdram_model #(.trcd(3), .trp(3), .trfc(6), .twr(1)) model (.clk(sys_clk),
		.cke(sdram_cke), .cs_n(sdram_cs_n), .ras_n(sdram_ras_n), .cas_n(sdram_cas_n),
		.we_n(sdram_we_n), .adr(sdram_adr), .ba(sdram_ba), .dqm(sdram_dqm), .dq(sdram_dq),
		.violation(model_violation), .cas_latency(model_cl), .refresh_count(model_refs));

	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk; // 4 ns period.
	end

	// ack may only rise while the master holds req.
	// req_q is req in the cycle that ended with the edge where ack rose.
	always @(posedge sys_clk) begin
		if (rst_n)
			assert (!(ack && !ack_q && !req_q)) else begin
				$display("ack rose while req was low");
				hs_errors++;
				errors++;
			end
		ack_q <= ack;
		req_q <= req;
	end

	task automatic tick();
		@(posedge sys_clk);
		#1; // inputs change 1 ns after the edge, outputs are sampled here too.
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (exp === act) else begin
			$display("FAILED %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int base);
		$display("test %s: %0d errors", name, errors - base);
	endtask

	task automatic csr_write(input logic [3:0] a, input logic [31:0] d);
		csr_a = a;
		csr_di = d;
		csr_we = 1'b1;
		tick();
		csr_we = 1'b0;
	endtask

	task automatic csr_read(input logic [3:0] a, output logic [31:0] d);
		csr_a = a;
		tick(); // csr_do is registered one cycle after csr_a.
		d = csr_do;
	endtask

	task automatic bypass_cmd(input logic [3:0] c, input logic [12:0] a);
		csr_write(4'd1, {12'd0, c, 1'b0, 2'd0, a});
	endtask

	function automatic logic [31:0] timing_word(input logic [2:0] rp, input logic [2:0] rcd,
		input logic cas, input logic [10:0] refi, input logic [3:0] rfc, input logic [1:0] wr);
		return {8'd0, wr, rfc, refi, cas, rcd, rp};
	endfunction

	// the last read of an address in the table holds the word left there at the end.
	function automatic logic [15:0] last_read_word(input logic [21:0] a);
		logic [15:0] w;
		w = 'x;
		for (int j = 0; j < t_name.size(); j++)
			if (!t_we[j] && t_adr[j] == a)
				w = t_exp[j];
		return w;
	endfunction

	task automatic bus_access(input string name, input logic w, input logic [21:0] a,
		input logic [15:0] d, input logic [1:0] s, output logic [15:0] q);
		int n;
		req = 1'b1;
		we = w;
		adr = a;
		wdata = d;
		sel = s;
		n = 0;
		while (!ack && n < 200) begin
			tick();
			n++;
		end
		if (!ack) begin
			$display("no ack for access %s", name);
			errors++;
		end
		q = rdata; // valid while ack is high.
		req = 1'b0;
		n = 0;
		while (ack && n < 8) begin
			tick();
			n++;
		end
		if (ack) begin
			$display("ack stayed high after req dropped in %s", name);
			hs_errors++;
			errors++;
		end
	endtask

	task automatic add_entry(input string n, input logic w, input logic [21:0] a,
		input logic [15:0] d, input logic [1:0] s, input logic [15:0] e);
		t_name.push_back(n);
		t_we.push_back(w);
		t_adr.push_back(a);
		t_wdata.push_back(d);
		t_sel.push_back(s);
		t_exp.push_back(e);
	endtask

	task automatic run_table(input logic reads_only);
		logic [15:0] q;
		logic [15:0] want;
		for (int i = 0; i < t_name.size(); i++) begin
			if (!(reads_only && t_we[i])) begin
				repeat ($urandom % 4) tick(); // random idle gap between accesses.
				bus_access(t_name[i], t_we[i], t_adr[i], t_wdata[i], t_sel[i], q);
				if (!t_we[i]) begin
					// a reread sees what every write of the first pass left behind.
					want = reads_only ? last_read_word(t_adr[i]) : t_exp[i];
					check_value(t_name[i], {16'd0, want}, {16'd0, q});
				end
			end
		end
	endtask

	initial begin
		logic [31:0] rd;
		int base;
		int refs;
		int min_refs;
		void'($urandom(32'h1b14));
		{rst_n, csr_we, req, we, ack_q, req_q} = '0;
		{csr_a, csr_di, adr, wdata, sel} = '0;
		{errors, checks, hs_errors} = '0;
		// address is {row, bank[9:8], column[7:0]}.
		add_entry("wr_b0", 1'b1, 22'h000000, 16'h1234, 2'b11, 16'h0000);
		add_entry("wr_b1", 1'b1, 22'h000105, 16'habcd, 2'b11, 16'h0000);
		add_entry("wr_b3_r2", 1'b1, 22'h000b7f, 16'h5a5a, 2'b11, 16'h0000);
		add_entry("rd_b0", 1'b0, 22'h000000, 16'h0000, 2'b11, 16'h1234);
		add_entry("rd_b1", 1'b0, 22'h000105, 16'h0000, 2'b11, 16'habcd);
		add_entry("wr_hi_byte", 1'b1, 22'h000000, 16'hee00, 2'b10, 16'h0000);
		add_entry("wr_lo_byte", 1'b1, 22'h000105, 16'h0077, 2'b01, 16'h0000);
		add_entry("rd_hi_merge", 1'b0, 22'h000000, 16'h0000, 2'b11, 16'hee34);
		add_entry("rd_lo_merge", 1'b0, 22'h000105, 16'h0000, 2'b11, 16'hab77);
		add_entry("rd_b3_r2", 1'b0, 22'h000b7f, 16'h0000, 2'b11, 16'h5a5a);
		add_entry("wr_r15", 1'b1, 22'h003c42, 16'hc3a5, 2'b11, 16'h0000);
		add_entry("rd_r15", 1'b0, 22'h003c42, 16'h0000, 2'b11, 16'hc3a5);

		repeat (8) @(posedge sys_clk);
		#1 rst_n = 1'b1;
		tick();

		// ***********************************************************************
		// reset state and CSR bring-up
		// ***********************************************************************
		base = errors;
		check_value("reset_ack", 32'd0, {31'd0, ack});
		check_value("reset_cke", 32'd0, {31'd0, sdram_cke});
		check_value("reset_pins", 32'hf, {28'd0, sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n});
		csr_read(4'd0, rd);
		check_value("reset_csr0", 32'd3, rd); // bypass and sdram_rst set, cke clear.
		report_test("reset", base);

		base = errors;
		csr_write(4'd2, timing_word(3'd3, 3'd3, 1'b0, 11'd740, 4'd6, 2'd1));
		csr_read(4'd2, rd);
		check_value("timing_readback", timing_word(3'd3, 3'd3, 1'b0, 11'd740, 4'd6, 2'd1), rd);
		csr_write(4'd0, 32'd7); // cke on, still in bypass.
		bypass_cmd(sdram_pkg::CMD_PRECHARGE, 13'h400); // a10 closes all banks.
		repeat (4) tick();
		bypass_cmd(sdram_pkg::CMD_MRS, 13'h020); // CL2, burst length 1.
		repeat (4) tick();
		check_value("mode_cl2", 32'd2, model_cl);
		csr_write(4'd0, 32'd4); // hand the pins to the management FSM.
		report_test("csr_init", base);

		base = errors;
		run_table(1'b0);
		check_value("violation_table", 32'd0, {31'd0, model_violation});
		report_test("table_cl2", base);

		// ***********************************************************************
		// refresh rate with a short interval
		// ***********************************************************************
		base = errors;
		csr_write(4'd0, 32'd5); // sdram_rst restarts the refresh counter.
		csr_write(4'd2, timing_word(3'd3, 3'd3, 1'b0, 11'd40, 4'd6, 2'd1));
		csr_write(4'd0, 32'd4);
		refs = model_refs;
		repeat (600) tick();
		refs = model_refs - refs;
		min_refs = 600 / (40 + 6 + 1) - 1;
		checks++;
		assert (refs >= min_refs) else begin
			$display("FAILED refresh_count expected >= %0d actual %0d", min_refs, refs);
			errors++;
		end
		check_value("violation_refresh", 32'd0, {31'd0, model_violation});
		report_test("refresh", base);

		base = errors;
		csr_write(4'd0, 32'd7); // back to bypass with the FSM held idle.
		repeat (16) tick(); // lets a refresh in flight finish.
		csr_write(4'd2, timing_word(3'd3, 3'd3, 1'b1, 11'd40, 4'd6, 2'd1));
		bypass_cmd(sdram_pkg::CMD_MRS, 13'h030); // CL3.
		repeat (4) tick();
		check_value("mode_cl3", 32'd3, model_cl);
		csr_write(4'd0, 32'd4);
		run_table(1'b1);
		check_value("violation_cl3", 32'd0, {31'd0, model_violation});
		report_test("table_cl3", base);

		$display("test handshake: %0d errors", hs_errors);
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/sdram_busif.sv */
// Four-phase req/ack port for one 16-bit word per access.
// Read data is valid on rdata while ack is high. DQ is driven only in the WRITE pin cycle.
`timescale 1ns/10ps
`default_nettype none

module sdram_busif #(
	parameter int sdram_depth = 22
) (
	input wire sys_clk,
	input wire rst_n,
	input wire sdram_rst,
	input wire tim_cas,
	input wire req,
	input wire we,
	input wire [sdram_depth-1:0] adr,
	input wire [sdram_pkg::DQ_WIDTH-1:0] wdata,
	input wire [sdram_pkg::DQ_WIDTH/8-1:0] sel,
	output logic ack,
	output logic [sdram_pkg::DQ_WIDTH-1:0] rdata,
	output logic mgmt_stb,
	output logic mgmt_we,
	output logic [sdram_depth-1:0] mgmt_address,
	input wire mgmt_ack,
	input wire data_read,
	input wire data_write,
	output logic [sdram_pkg::DQ_WIDTH/8-1:0] dqm,
	inout wire [sdram_pkg::DQ_WIDTH-1:0] dq
);

	logic [sdram_pkg::DQ_WIDTH-1:0] wdata_r; // write word held for the whole access.
	logic [sdram_pkg::DQ_WIDTH/8-1:0] sel_r;
	logic [sdram_pkg::DQ_WIDTH-1:0] dq_out;
	logic dq_oe;
	logic [3:0] rd_pipe; // bit k is data_read delayed by k+1 cycles.

	wire accept = req & ~ack & ~mgmt_stb; // no new request until the old ack has dropped.
	wire rd_capture = tim_cas ? rd_pipe[3] : rd_pipe[2]; // the data edge, CL+1 after data_read.

	always_ff @(posedge sys_clk) begin
		if (!rst_n || sdram_rst) begin
			mgmt_stb <= 1'b0;
			ack <= 1'b0;
			dq_oe <= 1'b0;
			dqm <= '0;
			rd_pipe <= '0;
		end else begin
			if (mgmt_ack) begin
				mgmt_stb <= 1'b0;
				ack <= 1'b1;
			end else if (accept) begin
				mgmt_stb <= 1'b1;
			end
			if (ack && !req)
				ack <= 1'b0; // the master has let go, so close the handshake.
			dq_oe <= data_write; // drives in the cycle the WRITE command is on the pins.
			dqm <= data_write ? ~sel_r : '0; // dqm is high for a byte that must not change.
			rd_pipe <= {rd_pipe[2:0], data_read};
		end
	end

	always_ff @(posedge sys_clk) begin
		if (accept) begin
			mgmt_we <= we;
			mgmt_address <= adr;
			wdata_r <= wdata;
			sel_r <= sel;
		end
		dq_out <= wdata_r;
		if (rd_capture)
			rdata <= dq;
	end

	assign dq = dq_oe ? dq_out : 'z;

endmodule

`default_nettype wire

/* verilog/sdram_ctlif.sv */
// Register map (csr_a[1:0]): 0 = {cke, bypass, sdram_rst}, 1 = bypass command,
// 2 = timing. Register 1 takes adr in [12:0], ba in [14:13], cmd in [19:16] and reads zero.
// Timing word: rp [2:0], rcd [5:3], cas [6] (0 = CL2, 1 = CL3), refi [17:7], rfc [21:18],
// wr [23:22].
`timescale 1ns/10ps
`default_nettype none

module sdram_ctlif #(
	parameter logic [1:0] csr_addr = 2'd0
) (
	input wire sys_clk,
	input wire rst_n,
	input wire [3:0] csr_a,
	input wire csr_we,
	input wire [31:0] csr_di,
	output logic [31:0] csr_do,
	output logic bypass,
	output logic sdram_rst,
	output logic cke,
	output sdram_pkg::sdram_cmd_t byp_cmd,
	output logic [sdram_pkg::ADR_WIDTH-1:0] byp_adr,
	output logic [sdram_pkg::BA_WIDTH-1:0] byp_ba,
	output logic [sdram_pkg::TRP_WIDTH-1:0] tim_rp,
	output logic [sdram_pkg::TRCD_WIDTH-1:0] tim_rcd,
	output logic tim_cas,
	output logic [sdram_pkg::TREFI_WIDTH-1:0] tim_refi,
	output logic [sdram_pkg::TRFC_WIDTH-1:0] tim_rfc,
	output logic [sdram_pkg::TWR_WIDTH-1:0] tim_wr
);

	wire csr_sel = (csr_a[3:2] == csr_addr); // the upper address bits pick this block.
	wire byp_wr = csr_sel & csr_we & (csr_a[1:0] == 2'd1); // a write to register 1.

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			sdram_rst <= 1'b1; // management and bus port stay idle until software is done.
			bypass <= 1'b1; // software owns the command pins after reset.
			cke <= 1'b0;
			byp_cmd <= sdram_pkg::CMD_NOP;
			tim_rp <= 3'd2;
			tim_rcd <= 3'd2;
			tim_cas <= 1'b0;
			tim_refi <= 11'd740;
			tim_rfc <= 4'd8;
			tim_wr <= 2'd1;
			csr_do <= 32'd0;
		end else begin
			// the bypass command lives for one cycle only, then falls back to NOP.
			byp_cmd <= byp_wr ? sdram_pkg::sdram_cmd_t'(csr_di[19:16]) : sdram_pkg::CMD_NOP;
			csr_do <= 32'd0; // an unselected block reads zero.
			if (csr_sel && csr_we && (csr_a[1:0] == 2'd0)) begin
				sdram_rst <= csr_di[0];
				bypass <= csr_di[1];
				cke <= csr_di[2];
			end
			if (csr_sel && csr_we && (csr_a[1:0] == 2'd2)) begin
				tim_rp <= csr_di[2:0];
				tim_rcd <= csr_di[5:3];
				tim_cas <= csr_di[6];
				tim_refi <= csr_di[17:7];
				tim_rfc <= csr_di[21:18];
				tim_wr <= csr_di[23:22];
			end
			if (csr_sel) begin
				case (csr_a[1:0])
				2'd0: csr_do <= {29'd0, cke, bypass, sdram_rst};
				2'd2: csr_do <= {8'd0, tim_wr, tim_rfc, tim_refi, tim_cas, tim_rcd, tim_rp};
				default: csr_do <= 32'd0; // register 1 is write only.
				endcase
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (byp_wr) begin
			byp_adr <= csr_di[12:0]; // mode word, or a10 for precharge all.
			byp_ba <= csr_di[14:13];
		end
	end

	// a bypass command lasts one cycle, so register 1 is never written two cycles in a row.
	byp_cmd_pulse: assert property (@(posedge sys_clk) disable iff (!rst_n)
		(byp_cmd != sdram_pkg::CMD_NOP) |=> (byp_cmd == sdram_pkg::CMD_NOP))
		else $error("bypass command held past one cycle");

endmodule

`default_nettype wire

/* verilog/sdram_ctrl.sv */
// Single-rank x16 SDR SDRAM controller. Software brings the chip up through the bypass
// path, then clears bypass and sdram_rst. Commands are held to DESELECT while cke is low.
// The SDRAM clock is sys_clk, generated outside this block.
`timescale 1ns/10ps
`default_nettype none

module sdram_ctrl #(
	parameter logic [1:0] csr_addr = 2'd0,
	parameter int sdram_depth = 22,
	parameter int sdram_columndepth = 8
) (
	input wire sys_clk,
	input wire rst_n,
	input wire [3:0] csr_a,
	input wire csr_we,
	input wire [31:0] csr_di,
	output logic [31:0] csr_do,
	input wire req,
	input wire we,
	input wire [sdram_depth-1:0] adr,
	input wire [sdram_pkg::DQ_WIDTH-1:0] wdata,
	input wire [sdram_pkg::DQ_WIDTH/8-1:0] sel,
	output logic ack,
	output logic [sdram_pkg::DQ_WIDTH-1:0] rdata,
	output logic sdram_cke,
	output logic sdram_cs_n,
	output logic sdram_ras_n,
	output logic sdram_cas_n,
	output logic sdram_we_n,
	output logic [sdram_pkg::ADR_WIDTH-1:0] sdram_adr,
	output logic [sdram_pkg::BA_WIDTH-1:0] sdram_ba,
	output logic [sdram_pkg::DQ_WIDTH/8-1:0] sdram_dqm,
	inout wire [sdram_pkg::DQ_WIDTH-1:0] sdram_dq
);

	logic bypass, sdram_rst, cke;
	sdram_pkg::sdram_cmd_t byp_cmd, mgmt_cmd, cmd_mux;
	logic [sdram_pkg::ADR_WIDTH-1:0] byp_adr, mgmt_adr, adr_mux;
	logic [sdram_pkg::BA_WIDTH-1:0] byp_ba, mgmt_ba, ba_mux;
	logic [sdram_pkg::TRP_WIDTH-1:0] tim_rp;
	logic [sdram_pkg::TRCD_WIDTH-1:0] tim_rcd;
	logic tim_cas;
	logic [sdram_pkg::TREFI_WIDTH-1:0] tim_refi;
	logic [sdram_pkg::TRFC_WIDTH-1:0] tim_rfc;
	logic [sdram_pkg::TWR_WIDTH-1:0] tim_wr;
	logic mgmt_stb, mgmt_we, mgmt_ack, data_read, data_write;
	logic [sdram_depth-1:0] mgmt_address;
	logic wait_load, wait_done, refresh_due, refresh_ack;
	logic [sdram_pkg::WAIT_WIDTH-1:0] wait_value;

	// ***********************************************************************
	// command source select and pin register
	// ***********************************************************************
	assign cmd_mux = bypass ? byp_cmd : mgmt_cmd;
	assign adr_mux = bypass ? byp_adr : mgmt_adr;
	assign ba_mux = bypass ? byp_ba : mgmt_ba;

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			sdram_cke <= 1'b0;
			{sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n} <= sdram_pkg::CMD_DESELECT;
		end else begin
			sdram_cke <= cke; // cke always comes from the control register.
			{sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n} <=
				cke ? cmd_mux : sdram_pkg::CMD_DESELECT;
		end
	end

	always_ff @(posedge sys_clk) begin
		sdram_adr <= adr_mux;
		sdram_ba <= ba_mux;
	end

	// ***********************************************************************
	// blocks
	// ***********************************************************************
	sdram_ctlif #(.csr_addr(csr_addr)) ctlif (
		.sys_clk(sys_clk), .rst_n(rst_n),
		.csr_a(csr_a), .csr_we(csr_we), .csr_di(csr_di), .csr_do(csr_do),
		.bypass(bypass), .sdram_rst(sdram_rst), .cke(cke),
		.byp_cmd(byp_cmd), .byp_adr(byp_adr), .byp_ba(byp_ba),
		.tim_rp(tim_rp), .tim_rcd(tim_rcd), .tim_cas(tim_cas),
		.tim_refi(tim_refi), .tim_rfc(tim_rfc), .tim_wr(tim_wr)
	);

	sdram_timer timer (
		.sys_clk(sys_clk), .rst_n(rst_n), .sdram_rst(sdram_rst), .tim_refi(tim_refi),
		.wait_load(wait_load), .wait_value(wait_value), .refresh_ack(refresh_ack),
		.wait_done(wait_done), .refresh_due(refresh_due)
	);

	sdram_mgmt #(.sdram_depth(sdram_depth), .sdram_columndepth(sdram_columndepth)) mgmt (
		.sys_clk(sys_clk), .rst_n(rst_n), .sdram_rst(sdram_rst),
		.tim_rp(tim_rp), .tim_rcd(tim_rcd), .tim_rfc(tim_rfc), .tim_wr(tim_wr),
		.tim_cas(tim_cas),
		.mgmt_stb(mgmt_stb), .mgmt_we(mgmt_we), .mgmt_address(mgmt_address),
		.mgmt_ack(mgmt_ack), .data_read(data_read), .data_write(data_write),
		.wait_load(wait_load), .wait_value(wait_value), .wait_done(wait_done),
		.refresh_due(refresh_due), .refresh_ack(refresh_ack),
		.cmd(mgmt_cmd), .adr(mgmt_adr), .ba(mgmt_ba)
	);

	sdram_busif #(.sdram_depth(sdram_depth)) busif (
		.sys_clk(sys_clk), .rst_n(rst_n), .sdram_rst(sdram_rst), .tim_cas(tim_cas),
		.req(req), .we(we), .adr(adr), .wdata(wdata), .sel(sel),
		.ack(ack), .rdata(rdata),
		.mgmt_stb(mgmt_stb), .mgmt_we(mgmt_we), .mgmt_address(mgmt_address),
		.mgmt_ack(mgmt_ack), .data_read(data_read), .data_write(data_write),
		.dqm(sdram_dqm), .dq(sdram_dq)
	);

endmodule

`default_nettype wire

/* verilog/sdram_mgmt.sv */
// One word per access: activate, then read or write with auto-precharge, then a full wait.
// No row is left open, so refresh may start from IDLE at once.
// Needs sdram_columndepth <= AP_BIT and a row that fits in ADR_WIDTH.
`timescale 1ns/10ps
`default_nettype none

module sdram_mgmt #(
	parameter int sdram_depth = 22,
	parameter int sdram_columndepth = 8
) (
	input wire sys_clk,
	input wire rst_n,
	input wire sdram_rst,
	input wire [sdram_pkg::TRP_WIDTH-1:0] tim_rp,
	input wire [sdram_pkg::TRCD_WIDTH-1:0] tim_rcd,
	input wire [sdram_pkg::TRFC_WIDTH-1:0] tim_rfc,
	input wire [sdram_pkg::TWR_WIDTH-1:0] tim_wr,
	input wire tim_cas,
	input wire mgmt_stb,
	input wire mgmt_we,
	input wire [sdram_depth-1:0] mgmt_address,
	output logic mgmt_ack,
	output logic data_read,
	output logic data_write,
	output logic wait_load,
	output logic [sdram_pkg::WAIT_WIDTH-1:0] wait_value,
	input wire wait_done,
	input wire refresh_due,
	output logic refresh_ack,
	output sdram_pkg::sdram_cmd_t cmd,
	output logic [sdram_pkg::ADR_WIDTH-1:0] adr,
	output logic [sdram_pkg::BA_WIDTH-1:0] ba
);

	localparam int row_width = sdram_depth - sdram_columndepth - sdram_pkg::BA_WIDTH;
	localparam int wait_width = sdram_pkg::WAIT_WIDTH;

	typedef enum logic [2:0] {
		IDLE, REFRESH, ACTIVATE, WAIT_RCD, ACCESS, WAIT_DATA, WAIT_PRE
	} state_t;

	state_t state;
	state_t next_state;
	logic [sdram_pkg::ADR_WIDTH-1:0] row_adr; // row, zero-extended onto the pins.
	logic [sdram_pkg::ADR_WIDTH-1:0] col_adr; // column with the auto-precharge bit set.

	// word address is {row, bank, column}, so neighbouring words share a row.
	assign ba = mgmt_address[sdram_columndepth +: sdram_pkg::BA_WIDTH];

	always_comb begin
		row_adr = '0;
		row_adr[row_width-1:0] = mgmt_address[sdram_depth-1 -: row_width];
		col_adr = '0;
		col_adr[sdram_columndepth-1:0] = mgmt_address[sdram_columndepth-1:0];
		col_adr[sdram_pkg::AP_BIT] = 1'b1;
	end

	always_ff @(posedge sys_clk) begin
		if (!rst_n || sdram_rst)
			state <= IDLE;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		case (state)
		IDLE: begin
			if (refresh_due)
				next_state = REFRESH; // refresh goes ahead of a waiting access.
			else if (mgmt_stb)
				next_state = ACTIVATE;
		end
		REFRESH: next_state = WAIT_PRE; // the final wait also covers tRFC.
		ACTIVATE: next_state = WAIT_RCD;
		WAIT_RCD: if (wait_done) next_state = ACCESS;
		ACCESS: next_state = WAIT_DATA;
		WAIT_DATA: if (wait_done) next_state = WAIT_PRE;
		WAIT_PRE: if (wait_done) next_state = IDLE;
		default: next_state = IDLE;
		endcase
	end

	// command and wait outputs are decoded from the state, and the top level registers them.
	always_comb begin
		cmd = sdram_pkg::CMD_NOP;
		adr = row_adr;
		wait_load = 1'b0;
		wait_value = '0;
		case (state)
		REFRESH: begin
			cmd = sdram_pkg::CMD_REFRESH;
			wait_load = 1'b1;
			wait_value = wait_width'(tim_rfc);
		end
		ACTIVATE: begin
			cmd = sdram_pkg::CMD_ACTIVE;
			wait_load = 1'b1;
			wait_value = wait_width'(tim_rcd);
		end
		ACCESS: begin
			cmd = mgmt_we ? sdram_pkg::CMD_WRITE : sdram_pkg::CMD_READ;
			adr = col_adr;
			wait_load = 1'b1;
			// a read waits CL+1 so the captured word is ready before ack.
			if (mgmt_we)
				wait_value = wait_width'(tim_wr);
			else
				wait_value = tim_cas ? wait_width'(4) : wait_width'(3);
		end
		WAIT_DATA: begin
			wait_load = wait_done; // the bank is precharging now, so wait out tRP.
			wait_value = wait_width'(tim_rp);
		end
		default: ;
		endcase
	end

	assign mgmt_ack = (state == WAIT_DATA) && wait_done; // one cycle, since the state moves on.
	assign data_read = (state == ACCESS) && !mgmt_we;
	assign data_write = (state == ACCESS) && mgmt_we;
	assign refresh_ack = (state == REFRESH);

	// a data phase only runs for a request that the bus port still holds.
	data_phase_stb: assert property (@(posedge sys_clk) disable iff (!rst_n || sdram_rst)
		(data_read || data_write) |-> mgmt_stb)
		else $error("data phase without a pending bus request");

endmodule

`default_nettype wire

/* verilog/sdram_pkg.sv */
// Shared constants for one x16 SDR SDRAM device.
// Commands are encoded as {cs_n, ras_n, cas_n, we_n}, in the order they sit on the pins.
`default_nettype none

package sdram_pkg;

	// ***********************************************************************
	// bus and pin widths
	// ***********************************************************************
	localparam int DQ_WIDTH = 16; // data pins, and also one bus word.
	localparam int BA_WIDTH = 2; // four internal banks.
	localparam int ADR_WIDTH = 13; // row and column share these pins.
	localparam int AP_BIT = 10; // a10 high on read or write asks for auto-precharge.

	// ***********************************************************************
	// command encoding
	// ***********************************************************************
	typedef enum logic [3:0] {
		CMD_NOP = 4'b0111,
		CMD_ACTIVE = 4'b0011,
		CMD_READ = 4'b0101,
		CMD_WRITE = 4'b0100,
		CMD_PRECHARGE = 4'b0010, // a10 high closes all banks.
		CMD_REFRESH = 4'b0001,
		CMD_MRS = 4'b0000, // mode register set, with the mode word on adr.
		CMD_DESELECT = 4'b1111 // chip not selected, so any other pin is ignored.
	} sdram_cmd_t;

	// ***********************************************************************
	// timing fields, counted in sys_clk cycles
	// ***********************************************************************
	localparam int TRP_WIDTH = 3; // precharge to activate.
	localparam int TRCD_WIDTH = 3; // activate to read or write.
	localparam int TRFC_WIDTH = 4; // refresh to the next command.
	localparam int TWR_WIDTH = 2; // write recovery.
	localparam int TREFI_WIDTH = 11; // refresh interval.
	localparam int WAIT_WIDTH = 4; // command-wait counter, wide enough for the widest field.

endpackage

`default_nettype wire

/* verilog/sdram_timer.sv */
// The refresh counter runs only while sdram_rst is low.
// A wait_value of 0 behaves like 1.
`timescale 1ns/10ps
`default_nettype none

module sdram_timer (
	input wire sys_clk,
	input wire rst_n,
	input wire sdram_rst,
	input wire [sdram_pkg::TREFI_WIDTH-1:0] tim_refi,
	input wire wait_load,
	input wire [sdram_pkg::WAIT_WIDTH-1:0] wait_value,
	input wire refresh_ack,
	output logic wait_done,
	output logic refresh_due
);

	logic [sdram_pkg::TREFI_WIDTH-1:0] refi_cnt; // cycles since the last refresh tick.
	logic [sdram_pkg::WAIT_WIDTH-1:0] wait_cnt; // cycles left before the next command.

	// ***********************************************************************
	// refresh interval
	// ***********************************************************************
	always_ff @(posedge sys_clk) begin
		if (!rst_n || sdram_rst) begin
			refi_cnt <= '0;
			refresh_due <= 1'b0;
		end else begin
			if (refi_cnt == tim_refi) begin
				refi_cnt <= '0; // the interval restarts right away, so ticks do not drift.
				refresh_due <= 1'b1; // a new tick wins over an ack in the same cycle.
			end else begin
				refi_cnt <= refi_cnt + 1'b1;
				if (refresh_ack)
					refresh_due <= 1'b0;
			end
		end
	end

	// ***********************************************************************
	// command spacing
	// ***********************************************************************
	always_ff @(posedge sys_clk) begin
		if (!rst_n || sdram_rst)
			wait_cnt <= '0;
		else if (wait_load)
			wait_cnt <= wait_value;
		else if (wait_cnt != '0)
			wait_cnt <= wait_cnt - 1'b1;
	end

	// done at a count of one, so a load of n ends exactly n cycles later.
	assign wait_done = (wait_cnt[sdram_pkg::WAIT_WIDTH-1:1] == '0);

	// the state machine loads a new wait only once the previous one has expired.
	wait_no_overlap: assert property (@(posedge sys_clk) disable iff (!rst_n || sdram_rst)
		wait_load |-> wait_done)
		else $error("wait_load while a command wait is still running");

endmodule

`default_nettype wire
